// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= nandDataOutputSyncTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+src
src/nandWritePkg.sv
src/nandCommandSequencer.sv
src/nandWriteFifo.sv
src/nandDqSerializer.sv
src/nandDataOutputSync.sv
test/nandDataOutputSyncTb.sv

// ==== src/nandCommandSequencer.sv ====
`timescale 1ns/10ps
`include "nandWriteDefs_defs.svh"

module nandCommandSequencer (
    input  logic                     iSystemClock,
    input  logic                     arstN,
    input  logic                     iStart,
    input  nandWritePkg::wayMaskT    iTargetWay,
    input  nandWritePkg::byteCountT  iNumOfData,
    input  logic                     burstAck,
    output logic                     oReady,
    output logic                     oLastStep,
    output nandWritePkg::chipEnableT oChipEnable,
    output logic                     burstReq,
    output nandWritePkg::byteCountT  burstLength
);
    import nandWritePkg::*;

    localparam logic [3:0] PreambleLoad = 4'(`NAND_TDQSS_CYCLES - 1);
    localparam logic [3:0] PostambleLoad = 4'(`NAND_TWPST_CYCLES - 1);

    seqStateT   state;
    wayMaskT    targetWay;
    logic       ceActive;
    logic [3:0] timer;   // shared by preamble and postamble

    assign oChipEnable = ceActive ? {targetWay, targetWay} : '0;

    // command capture
    always_ff @(posedge iSystemClock) begin
        if (oReady && iStart) begin
            targetWay   <= iTargetWay;
            burstLength <= iNumOfData;
        end
    end

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            state     <= SEQ_IDLE;
            oReady    <= 1'b0;
            oLastStep <= 1'b0;
            ceActive  <= 1'b0;
            burstReq  <= 1'b0;
            timer     <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (oReady && iStart) begin
                        oReady   <= 1'b0;
                        ceActive <= 1'b1;
                        state    <= SEQ_LATCH;
                    end else begin
                        oReady <= 1'b1;
                    end
                end
                SEQ_LATCH: begin
                    timer <= PreambleLoad;
                    state <= SEQ_PREAMBLE;
                end
                SEQ_PREAMBLE: begin
                    // previous handshake must be fully closed
                    if (timer == '0 && !burstAck) begin
                        burstReq <= 1'b1;
                        state    <= SEQ_BURST;
                    end else if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end
                end
                SEQ_BURST: begin
                    if (burstAck) begin
                        burstReq <= 1'b0;
                        timer    <= PostambleLoad;
                        state    <= SEQ_POSTAMBLE;
                    end
                end
                SEQ_POSTAMBLE: begin
                    if (timer == '0) begin
                        oLastStep <= 1'b1;
                        state     <= SEQ_FINISH;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                SEQ_FINISH: begin
                    oLastStep <= 1'b0;   // single cycle pulse
                    ceActive  <= 1'b0;
                    oReady    <= 1'b1;
                    state     <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // serializer counts against this value for the whole burst
    burstLengthHeld: assert property (@(posedge iSystemClock) disable iff (!arstN)
        burstReq |=> !burstReq || $stable(burstLength))
        else $error("burstLength changed during an open burst request");

endmodule

// ==== src/nandDataOutputSync.sv ====
`timescale 1ns/10ps

module nandDataOutputSync (
    input  logic                     iSystemClock,
    input  logic                     arstN,
    input  logic                     iStart,
    input  nandWritePkg::wayMaskT    iTargetWay,
    input  nandWritePkg::byteCountT  iNumOfData,
    output logic                     oReady,
    output logic                     oLastStep,
    input  nandWritePkg::dataWordT   iWriteData,
    input  logic                     iWriteValid,
    output logic                     oWriteReady,
    output nandWritePkg::dqBusT      oDq,
    output nandWritePkg::strobeT     oDqStrobe,
    output nandWritePkg::chipEnableT oChipEnable
);
    import nandWritePkg::*;

    dataWordT  fifoData;
    logic      fifoValid;
    logic      fifoPop;
    logic      burstReq;   // four-phase burst handover
    logic      burstAck;
    byteCountT burstLength;

    nandCommandSequencer commandSequencer (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .iStart       (iStart),
        .iTargetWay   (iTargetWay),
        .iNumOfData   (iNumOfData),
        .burstAck     (burstAck),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oChipEnable  (oChipEnable),
        .burstReq     (burstReq),
        .burstLength  (burstLength)
    );

    nandWriteFifo writeFifo (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .iWriteData   (iWriteData),
        .iWriteValid  (iWriteValid),
        .fifoPop      (fifoPop),
        .oWriteReady  (oWriteReady),
        .fifoData     (fifoData),
        .fifoValid    (fifoValid)
    );

    nandDqSerializer dqSerializer (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .burstReq     (burstReq),
        .burstLength  (burstLength),
        .fifoData     (fifoData),
        .fifoValid    (fifoValid),
        .fifoPop      (fifoPop),
        .burstAck     (burstAck),
        .oDq          (oDq),
        .oDqStrobe    (oDqStrobe)
    );

endmodule

// ==== src/nandDqSerializer.sv ====
`timescale 1ns/10ps

module nandDqSerializer (
    input  logic                    iSystemClock,
    input  logic                    arstN,
    input  logic                    burstReq,
    input  nandWritePkg::byteCountT burstLength,
    input  nandWritePkg::dataWordT  fifoData,
    input  logic                    fifoValid,
    output logic                    fifoPop,
    output logic                    burstAck,
    output nandWritePkg::dqBusT     oDq,
    output nandWritePkg::strobeT    oDqStrobe
);
    import nandWritePkg::*;

    localparam strobeT BeatStrobe = 8'b0000_1100;

    byteCountT  byteCount;
    logic       bytesLeft;
    logic [7:0] upperByte;
    logic [7:0] lowerByte;

    assign upperByte = fifoData[15:8];
    assign lowerByte = fifoData[7:0];
    assign bytesLeft = (byteCount < burstLength);

    // take every word the FIFO offers until the burst is complete
    assign fifoPop = burstReq && !burstAck && bytesLeft && fifoValid;

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            byteCount <= '0;
            burstAck  <= 1'b0;
            oDqStrobe <= '0;
        end else begin
            oDqStrobe <= fifoPop ? BeatStrobe : '0;   // zero between beats
            if (fifoPop) begin
                byteCount <= byteCount + 16'd2;
            end
            if (burstReq && !burstAck && !bytesLeft) begin
                burstAck <= 1'b1;
            end else if (burstAck && !burstReq) begin
                burstAck  <= 1'b0;
                byteCount <= '0;
            end
        end
    end

    // holds last beat during gaps
    always_ff @(posedge iSystemClock) begin
        if (fifoPop) begin
            oDq <= {upperByte, upperByte, lowerByte, lowerByte};
        end
    end

    ackOnlyUnderReq: assert property (@(posedge iSystemClock) disable iff (!arstN)
        $rose(burstAck) |-> burstReq)
        else $error("burstAck raised without a burst request");

endmodule

// ==== src/nandWriteDefs_defs.svh ====
`ifndef NAND_WRITE_DEFS_SVH
`define NAND_WRITE_DEFS_SVH

// channel geometry
`define NAND_NUM_WAYS 4
`define NAND_DATA_WIDTH 16

// host word buffer entries
`define NAND_FIFO_DEPTH 8

// write preamble in clock cycles before the first beat
`define NAND_TDQSS_CYCLES 2

// write postamble after the last beat
`define NAND_TWPST_CYCLES 2

`endif

// ==== src/nandWriteFifo.sv ====
`timescale 1ns/10ps
`include "nandWriteDefs_defs.svh"

module nandWriteFifo (
    input  logic                   iSystemClock,
    input  logic                   arstN,
    input  nandWritePkg::dataWordT iWriteData,
    input  logic                   iWriteValid,
    input  logic                   fifoPop,
    output logic                   oWriteReady,
    output nandWritePkg::dataWordT fifoData,
    output logic                   fifoValid
);
    import nandWritePkg::*;

    localparam int Depth = `NAND_FIFO_DEPTH;
    localparam int AddrWidth = $clog2(Depth);
    localparam logic [AddrWidth:0] FullCount = (AddrWidth + 1)'(Depth);

    dataWordT             mem [Depth];
    logic [AddrWidth-1:0] wrPtr;
    logic [AddrWidth-1:0] rdPtr;
    logic [AddrWidth:0]   count;
    logic [AddrWidth:0]   nextCount;
    logic                 push;

    function automatic logic [AddrWidth-1:0] nextPtr(input logic [AddrWidth-1:0] ptr);
        return (ptr == AddrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push      = iWriteValid && oWriteReady;
    assign fifoData  = mem[rdPtr];   // head word without read latency
    assign fifoValid = (count != '0);

    always_comb begin
        nextCount = count;
        if (push && !fifoPop) begin
            nextCount = count + 1'b1;
        end else if (!push && fifoPop) begin
            nextCount = count - 1'b1;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (push) begin
            mem[wrPtr] <= iWriteData;
        end
    end

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            oWriteReady <= 1'b0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (fifoPop) rdPtr <= nextPtr(rdPtr);
            count       <= nextCount;
            oWriteReady <= (nextCount != FullCount);   // registered full flag
        end
    end

    noPopWhenEmpty: assert property (@(posedge iSystemClock) disable iff (!arstN)
        fifoPop |-> fifoValid)
        else $error("pop from empty write FIFO");

    noOverfill: assert property (@(posedge iSystemClock) disable iff (!arstN)
        count <= FullCount)
        else $error("write FIFO occupancy above depth");

endmodule

// ==== src/nandWritePkg.sv ====
`include "nandWriteDefs_defs.svh"

package nandWritePkg;

    typedef logic [`NAND_NUM_WAYS-1:0] wayMaskT;
    typedef logic [2*`NAND_NUM_WAYS-1:0] chipEnableT; // both CE halves

    typedef logic [`NAND_DATA_WIDTH-1:0] dataWordT;
    typedef logic [15:0] byteCountT;

    // pin side
    typedef logic [31:0] dqBusT;
    typedef logic [7:0] strobeT;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LATCH,
        SEQ_PREAMBLE,
        SEQ_BURST,      // serializer owns the data
        SEQ_POSTAMBLE,
        SEQ_FINISH
    } seqStateT;

endpackage

// ==== test/nandDataOutputSyncTb.sv ====
`timescale 1ns/10ps
`include "nandWriteDefs_defs.svh"

module nandDataOutputSyncTb;
    import nandWritePkg::*;

    localparam strobeT BeatStrobe = 8'b0000_1100;
    localparam int WaitLimit = 2000;

    logic       iSystemClock;
    logic       arstN;
    logic       iStart;
    wayMaskT    iTargetWay;
    byteCountT  iNumOfData;
    logic       oReady;
    logic       oLastStep;
    dataWordT   iWriteData;
    logic       iWriteValid;
    logic       oWriteReady;
    dqBusT      oDq;
    strobeT     oDqStrobe;
    chipEnableT oChipEnable;

    dataWordT    expectedWords[$];   // accepted host words in arrival order
    int          errorCount;
    int          testsRun;
    int          testsFailed;
    int          testStartErrors;
    int          beatsSeen;
    int          cyclesSinceStart;
    bit          cmdOpen;
    bit          timedOut;
    bit          hostOn;
    int          validPercent;
    wayMaskT     activeMask;

    nandDataOutputSync nandDataOutputSync_i (.*);

    always #5 iSystemClock = ~iSystemClock;

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            errorCount++;
        end
    endtask

    task automatic checkTrue(bit cond, string what);
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            errorCount++;
        end
    endtask

    task automatic noteTimeout(bit reached, string what);
        assert (reached) else begin
            $display("ERROR at %0t: timed out waiting for %s", $time, what);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    // check outputs on the falling edge and then drive the host stream
    task automatic step();
        dataWordT word;
        @(negedge iSystemClock);
        cyclesSinceStart++;
        if (oDqStrobe === BeatStrobe) begin
            checkTrue(cmdOpen && cyclesSinceStart > `NAND_TDQSS_CYCLES,
                "beat outside the data phase of a command");
            checkTrue(expectedWords.size() > 0, "beat with no accepted word left");
            if (expectedWords.size() > 0) begin
                word = expectedWords.pop_front();
                checkValue("oDq", oDq, {word[15:8], word[15:8], word[7:0], word[7:0]});
            end
            beatsSeen++;
        end else begin
            checkValue("oDqStrobe", oDqStrobe, 32'h0);
        end
        // model now holds exactly the words still buffered in the FIFO
        checkValue("oWriteReady", oWriteReady, expectedWords.size() != `NAND_FIFO_DEPTH);
        checkTrue(cmdOpen || !oLastStep, "oLastStep pulse outside a command");
        if (oReady) checkValue("oChipEnable", oChipEnable, 32'h0);
        else if (cmdOpen) checkValue("oChipEnable", oChipEnable, {activeMask, activeMask});
        iWriteValid = hostOn && (($urandom % 100) < validPercent);
        iWriteData  = dataWordT'($urandom);
        if (iWriteValid && oWriteReady) expectedWords.push_back(iWriteData);   // taken next edge
    endtask

    task automatic waitReady(int limit, string what);
        int waited;
        waited = 0;
        while (!oReady && waited < limit) begin
            step();
            waited++;
        end
        noteTimeout(oReady, what);
    endtask

    task automatic runCommand(wayMaskT mask, byteCountT numBytes);
        int waited;
        waitReady(WaitLimit, "oReady before a start");
        if (timedOut) return;
        iStart           = 1'b1;
        iTargetWay       = mask;
        iNumOfData       = numBytes;
        activeMask       = mask;
        cmdOpen          = 1'b1;
        beatsSeen        = 0;
        cyclesSinceStart = 0;
        step();
        iStart = 1'b0;
        checkValue("oReady", oReady, 32'h0);
        waited = 0;
        while (!oLastStep && waited < WaitLimit) begin
            step();
            waited++;
        end
        noteTimeout(oLastStep, "oLastStep");
        checkValue("beat count", beatsSeen, numBytes / 2);
        step();
        checkValue("oLastStep", oLastStep, 32'h0);   // one cycle only
        checkValue("oReady", oReady, 32'h1);
        cmdOpen = 1'b0;
    endtask

    task automatic finishTest(string name);
        testsRun++;
        if (errorCount != testStartErrors) begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errorCount - testStartErrors);
        end else begin
            $display("test %s: ok", name);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        iSystemClock = 1'b0;
        arstN        = 1'b0;
        iStart       = 1'b0;
        iTargetWay   = '0;
        iNumOfData   = '0;
        iWriteData   = '0;
        iWriteValid  = 1'b0;
        hostOn       = 1'b0;
        validPercent = 0;
        cmdOpen      = 1'b0;
        void'($urandom(32'ha020_cf01));

        repeat (8) begin
            @(negedge iSystemClock);
            checkValue("oReady/oLastStep/oChipEnable/oDqStrobe",
                {oReady, oLastStep, oChipEnable, oDqStrobe}, 32'h0);
        end
        arstN = 1'b1;
        waitReady(4, "oReady after reset");
        finishTest("reset values");

        // fill the FIFO before any command
        hostOn       = 1'b1;
        validPercent = 100;
        begin : fillLoop
            int waited;
            waited = 0;
            while (oWriteReady !== 1'b0 && waited < WaitLimit) begin
                step();
                waited++;
            end
            noteTimeout(oWriteReady === 1'b0, "oWriteReady to fall");
        end
        checkValue("accepted words", expectedWords.size(), `NAND_FIFO_DEPTH);
        hostOn = 1'b0;
        runCommand(4'b0101, byteCountT'(2 * `NAND_FIFO_DEPTH));
        checkValue("words left in model", expectedWords.size(), 32'h0);
        finishTest("back-pressure");

        hostOn = 1'b1;
        for (int i = 0; i < 12 && !timedOut; i++) begin
            validPercent = 30 + int'($urandom % 71);
            runCommand(wayMaskT'($urandom), byteCountT'(2 * (1 + $urandom % 12)));
        end
        finishTest("random commands");

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
